//--- src/be_config.svh
// Build-time sizing of the execution back end
`ifndef BE_CONFIG_SVH
`define BE_CONFIG_SVH

// Calculator pipes fed round-robin, at least 2
`define BE_NUM_LANES 4

// Result buffer depth per pipe, one credit per entry
`define BE_LANE_CREDITS 2

// Committed-instruction counter, wraps
`define BE_COUNT_WIDTH 16

`endif

//--- src/be_pkg.sv
// Instruction, opcode and result types shared across the execution back end
`default_nettype none
`include "be_config.svh"

package be_pkg;

   // Codes 0..4 take the register form, 8..10 the shift form
   typedef enum logic [3:0] {
      e_op_add = 4'd0,
      e_op_sub = 4'd1,
      e_op_and = 4'd2,
      e_op_or  = 4'd3,
      e_op_xor = 4'd4,
      e_op_sll = 4'd8,
      e_op_srl = 4'd9,
      e_op_sra = 4'd10
   } be_opcode_e;

   typedef struct packed {
      logic signed [13:0] op_a;
      logic signed [13:0] op_b;
   } be_reg_form_s;

   typedef struct packed {
      logic signed [13:0] src;
      logic        [4:0]  shamt;
      logic        [8:0]  unused;
   } be_shift_form_s;

   // Same 28 bits, read one way or the other by opcode
   typedef union packed {
      be_reg_form_s   reg_form;
      be_shift_form_s shift_form;
   } be_payload_u;

   typedef struct packed {
      be_opcode_e  opcode;
      be_payload_u payload;
   } be_instr_s;

   typedef logic [31:0] be_word_t;

   typedef logic [`BE_COUNT_WIDTH-1:0] be_count_t;

endpackage

`default_nettype wire

//--- src/be_lane_if.sv
// Issue and result handshake between the checker, one calculator pipe and the commit unit
`timescale 1ns/1ps
`default_nettype none

interface be_lane_if
   import be_pkg::*;
   ();

   // Issue side, one-cycle pulse per instruction
   logic      issue_v;
   be_instr_s issue_instr;

   // Head of the pipe's result buffer
   logic      res_v;
   be_word_t  res_data;
   logic      res_yumi;

   // res_yumi also hands a credit back to the checker
   modport chk (
      output issue_v,
      output issue_instr,
      input  res_yumi
   );

   modport pipe (
      input  issue_v,
      input  issue_instr,
      output res_v,
      output res_data,
      input  res_yumi
   );

   modport cmt (
      input  res_v,
      input  res_data,
      output res_yumi
   );

endinterface

`default_nettype wire

//--- src/be_checker.sv
// Issue checker, takes words from the front-end queue and issues them round-robin on credit
`timescale 1ns/1ps
`default_nettype none
`include "be_config.svh"

module be_checker
   import be_pkg::*;
   (input wire             clk_i
   , input wire            rst_n_i

   , input wire be_instr_s fe_queue_i
   , input wire            fe_queue_v_i
   , output logic          fe_queue_yumi_o

   , be_lane_if.chk        lanes [`BE_NUM_LANES]
   );

   localparam int lanes_lp   = `BE_NUM_LANES;
   localparam int credits_lp = `BE_LANE_CREDITS;
   localparam int ptr_w_lp   = $clog2(lanes_lp);
   localparam int cred_w_lp  = $clog2(credits_lp + 1);

   logic [ptr_w_lp-1:0]  issue_ptr_r;
   logic [cred_w_lp-1:0] credit_cnt_r [lanes_lp];
   logic [lanes_lp-1:0]  issue_sel;
   logic [lanes_lp-1:0]  issue_v_r;
   logic [lanes_lp-1:0]  res_yumi_li;
   logic                 has_credit;

   // Only the pointed lane may take the word
   assign has_credit      = (credit_cnt_r[issue_ptr_r] != '0);
   assign fe_queue_yumi_o = fe_queue_v_i && has_credit;

   for (genvar i = 0; i < lanes_lp; i++) begin : g_lane
      assign issue_sel[i]   = fe_queue_yumi_o && (issue_ptr_r == ptr_w_lp'(i));
      assign res_yumi_li[i] = lanes[i].res_yumi;
      assign lanes[i].issue_v = issue_v_r[i];

      always_ff @(posedge clk_i) begin
         if (issue_sel[i]) begin
            lanes[i].issue_instr <= fe_queue_i;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         issue_ptr_r <= '0;
      end else if (fe_queue_yumi_o) begin
         if (issue_ptr_r == ptr_w_lp'(lanes_lp - 1)) begin
            issue_ptr_r <= '0;
         end else begin
            issue_ptr_r <= issue_ptr_r + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         issue_v_r <= '0;
      end else begin
         issue_v_r <= issue_sel;
      end
   end

   // Issue and return in one cycle cancel out
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < lanes_lp; i++) begin
            credit_cnt_r[i] <= cred_w_lp'(credits_lp);
         end
      end else begin
         for (int i = 0; i < lanes_lp; i++) begin
            if (issue_sel[i] && !res_yumi_li[i]) begin
               credit_cnt_r[i] <= credit_cnt_r[i] - 1'b1;
            end else if (res_yumi_li[i] && !issue_sel[i]) begin
               credit_cnt_r[i] <= credit_cnt_r[i] + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- src/be_calc_pipe.sv
// Calculator pipe, decode and execute stages feeding a credit-sized result buffer
`timescale 1ns/1ps
`default_nettype none
`include "be_config.svh"

module be_calc_pipe
   import be_pkg::*;
   (input wire      clk_i
   , input wire     rst_n_i

   , be_lane_if.pipe lane
   );

   localparam int depth_lp = `BE_LANE_CREDITS;
   localparam int ptr_w_lp = (depth_lp > 1) ? $clog2(depth_lp) : 1;
   localparam int cnt_w_lp = $clog2(depth_lp + 1);

   be_payload_u         payload_li;
   be_word_t            a_d;
   be_word_t            b_d;
   logic [4:0]          shamt_d;

   logic                s1_v_r;
   be_opcode_e          s1_op_r;
   be_word_t            s1_a_r;
   be_word_t            s1_b_r;
   logic [4:0]          s1_shamt_r;
   be_word_t            exe_result;

   be_word_t            buf_mem [depth_lp];
   logic [ptr_w_lp-1:0] wr_ptr_r;
   logic [ptr_w_lp-1:0] rd_ptr_r;
   logic [cnt_w_lp-1:0] count_r;

   function automatic be_word_t sext14(input logic [13:0] v);
      return {{18{v[13]}}, v};
   endfunction

   function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] p);
      return (p == ptr_w_lp'(depth_lp - 1)) ? '0 : p + 1'b1;
   endfunction

   // Stage one picks the payload view from the opcode
   assign payload_li = lane.issue_instr.payload;

   always_comb begin
      // Operand a sits in the same bits in both forms
      a_d     = sext14(payload_li.reg_form.op_a);
      b_d     = '0;
      shamt_d = '0;
      case (lane.issue_instr.opcode)
         e_op_sll, e_op_srl, e_op_sra: begin
            shamt_d = payload_li.shift_form.shamt;
         end
         default: begin
            b_d = sext14(payload_li.reg_form.op_b);
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         s1_v_r <= 1'b0;
      end else begin
         s1_v_r <= lane.issue_v;
      end
   end

   always_ff @(posedge clk_i) begin
      if (lane.issue_v) begin
         s1_op_r    <= lane.issue_instr.opcode;
         s1_a_r     <= a_d;
         s1_b_r     <= b_d;
         s1_shamt_r <= shamt_d;
      end
   end

   // Stage two result lands in the buffer on the next edge
   always_comb begin
      case (s1_op_r)
         e_op_add: exe_result = s1_a_r + s1_b_r;
         e_op_sub: exe_result = s1_a_r - s1_b_r;
         e_op_and: exe_result = s1_a_r & s1_b_r;
         e_op_or:  exe_result = s1_a_r | s1_b_r;
         e_op_xor: exe_result = s1_a_r ^ s1_b_r;
         e_op_sll: exe_result = s1_a_r << s1_shamt_r;
         e_op_srl: exe_result = s1_a_r >> s1_shamt_r;
         e_op_sra: exe_result = be_word_t'($signed(s1_a_r) >>> s1_shamt_r);
         default:  exe_result = '1;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (s1_v_r) begin
         buf_mem[wr_ptr_r] <= exe_result;
      end
   end

   // The checker holds one credit per buffer entry, so no overflow
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end else begin
         if (s1_v_r) begin
            wr_ptr_r <= next_ptr(wr_ptr_r);
         end
         if (lane.res_yumi) begin
            rd_ptr_r <= next_ptr(rd_ptr_r);
         end
         if (s1_v_r && !lane.res_yumi) begin
            count_r <= count_r + 1'b1;
         end else if (lane.res_yumi && !s1_v_r) begin
            count_r <= count_r - 1'b1;
         end
      end
   end

   assign lane.res_v    = (count_r != '0);
   assign lane.res_data = buf_mem[rd_ptr_r];

endmodule

`default_nettype wire

//--- src/be_commit.sv
// Commit unit, drains the lanes in issue order onto a valid/ready port
`timescale 1ns/1ps
`default_nettype none
`include "be_config.svh"

module be_commit
   import be_pkg::*;
   (input wire         clk_i
   , input wire        rst_n_i

   , be_lane_if.cmt    lanes [`BE_NUM_LANES]

   , output logic      commit_v_o
   , output be_word_t  commit_data_o
   , input wire        commit_ready_i
   , output be_count_t commit_count_o
   );

   localparam int lanes_lp = `BE_NUM_LANES;
   localparam int ptr_w_lp = $clog2(lanes_lp);

   logic [lanes_lp-1:0] res_v_li;
   be_word_t            res_data_li [lanes_lp];
   logic [ptr_w_lp-1:0] head_ptr_r;
   logic                xfer;

   for (genvar i = 0; i < lanes_lp; i++) begin : g_lane
      assign res_v_li[i]       = lanes[i].res_v;
      assign res_data_li[i]    = lanes[i].res_data;
      assign lanes[i].res_yumi = xfer && (head_ptr_r == ptr_w_lp'(i));
   end

   // Head lane only, others wait their turn
   assign commit_v_o    = res_v_li[head_ptr_r];
   assign commit_data_o = res_data_li[head_ptr_r];
   assign xfer          = commit_v_o && commit_ready_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         head_ptr_r <= '0;
      end else if (xfer) begin
         if (head_ptr_r == ptr_w_lp'(lanes_lp - 1)) begin
            head_ptr_r <= '0;
         end else begin
            head_ptr_r <= head_ptr_r + 1'b1;
         end
      end
   end

   // wraps at 2^BE_COUNT_WIDTH
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         commit_count_o <= '0;
      end else if (xfer) begin
         commit_count_o <= commit_count_o + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- src/be_top.sv
// Execution back end top, checker feeding the calculator pipes and the commit unit
`timescale 1ns/1ps
`default_nettype none
`include "be_config.svh"

module be_top
   import be_pkg::*;
   (input wire                          clk_i
   , input wire                         rst_n_i

   // Front-end queue
   , input wire [31:0]                  fe_queue_i
   , input wire                         fe_queue_v_i
   , output logic                       fe_queue_yumi_o

   // Commit port
   , output logic                       commit_v_o
   , output logic [31:0]                commit_data_o
   , input wire                         commit_ready_i
   , output logic [`BE_COUNT_WIDTH-1:0] commit_count_o
   );

   be_instr_s fe_queue_li;
   be_word_t  commit_data_lo;
   be_count_t commit_count_lo;

   assign fe_queue_li    = be_instr_s'(fe_queue_i);
   assign commit_data_o  = commit_data_lo;
   assign commit_count_o = commit_count_lo;

   be_lane_if lane_if [`BE_NUM_LANES] ();

   be_checker be_chk0
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.fe_queue_i(fe_queue_li)
      ,.fe_queue_v_i(fe_queue_v_i)
      ,.fe_queue_yumi_o(fe_queue_yumi_o)
      ,.lanes(lane_if)
      );

   for (genvar i = 0; i < `BE_NUM_LANES; i++) begin : g_pipe
      be_calc_pipe be_pipe
        (.clk_i(clk_i)
         ,.rst_n_i(rst_n_i)
         ,.lane(lane_if[i])
         );
   end

   be_commit be_cmt0
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.lanes(lane_if)
      ,.commit_v_o(commit_v_o)
      ,.commit_data_o(commit_data_lo)
      ,.commit_ready_i(commit_ready_i)
      ,.commit_count_o(commit_count_lo)
      );

endmodule

`default_nettype wire

//--- verification/be_assertions.sv
// Credit and issue-order assertions for the back end checker
`timescale 1ns/1ps
`default_nettype none
`include "be_config.svh"

module be_assertions
   #(parameter int lanes_p  = `BE_NUM_LANES
   , parameter int cred_w_p = $clog2(`BE_LANE_CREDITS + 1)
   )
   (input wire                 clk_i
   , input wire                rst_n_i
   , input wire                fe_queue_v_i
   , input wire                fe_queue_yumi_o
   , input wire [lanes_p-1:0]  issue_sel
   , input wire [lanes_p-1:0]  issue_v
   , input wire [lanes_p-1:0]  res_yumi
   , input logic [cred_w_p-1:0] credit_cnt [lanes_p]
   );

   logic [cred_w_p-1:0] inflight_r [lanes_p];

   // Words issued to each lane and not yet drained by the commit unit
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < lanes_p; i++) begin
            inflight_r[i] <= '0;
         end
      end else begin
         for (int i = 0; i < lanes_p; i++) begin
            inflight_r[i] <= inflight_r[i] + cred_w_p'(issue_sel[i])
                             - cred_w_p'(res_yumi[i]);
         end
      end
   end

   for (genvar i = 0; i < lanes_p; i++) begin : g_lane
      a_issue_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         issue_sel[i] |-> (inflight_r[i] < cred_w_p'(`BE_LANE_CREDITS)))
         else $error("lane %0d issued with zero credits", i);

      a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         credit_cnt[i] <= cred_w_p'(`BE_LANE_CREDITS))
         else $error("lane %0d credit counter above its limit", i);
   end

   a_issue_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(issue_v))
      else $error("issue_v high on more than one lane");

   a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      fe_queue_yumi_o |-> fe_queue_v_i)
      else $error("fe_queue_yumi_o high without fe_queue_v_i");

endmodule

`default_nettype wire

//--- verification/be_tb.sv
// Testbench for the execution back end, random and directed words against a reference model
`timescale 1ns/1ps
`default_nettype none
`include "be_config.svh"

module be_tb
   import be_pkg::*;
   ();

   localparam int stall_accepts_lp = `BE_NUM_LANES * `BE_LANE_CREDITS;
   localparam int num_random_lp    = 400;
   // Directed words are 5 register, 9 shift and 8 illegal
   localparam int num_instr_lp     = 22 + num_random_lp + stall_accepts_lp;
   localparam int timeout_lp       = 20 * num_instr_lp + 200;

   logic        clk_i;
   logic        rst_n_i;
   logic [31:0] fe_queue_i;
   logic        fe_queue_v_i;
   logic        fe_queue_yumi_o;
   logic        commit_v_o;
   logic [31:0] commit_data_o;
   logic        commit_ready_i;
   logic [`BE_COUNT_WIDTH-1:0] commit_count_o;

   logic [31:0] sent_q [$];
   int          accept_cnt;
   int          cycle_cnt;
   int          seed;
   string       test_name;

   be_top dut0
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.fe_queue_i(fe_queue_i)
      ,.fe_queue_v_i(fe_queue_v_i)
      ,.fe_queue_yumi_o(fe_queue_yumi_o)
      ,.commit_v_o(commit_v_o)
      ,.commit_data_o(commit_data_o)
      ,.commit_ready_i(commit_ready_i)
      ,.commit_count_o(commit_count_o)
      );

   bind be_checker be_assertions asrt0
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.fe_queue_v_i(fe_queue_v_i)
      ,.fe_queue_yumi_o(fe_queue_yumi_o)
      ,.issue_sel(issue_sel)
      ,.issue_v(issue_v_r)
      ,.res_yumi(res_yumi_li)
      ,.credit_cnt(credit_cnt_r)
      );

   always #20 clk_i = ~clk_i;

   // Expected result straight from the opcode table and the execution rule
   function automatic be_word_t be_ref_exec(input logic [31:0] w);
      int a;
      int b;
      int sh;
      a  = $signed(w[27:14]);
      b  = $signed(w[13:0]);
      sh = w[13:9];
      case (w[31:28])
         4'd0:    return a + b;
         4'd1:    return a - b;
         4'd2:    return a & b;
         4'd3:    return a | b;
         4'd4:    return a ^ b;
         4'd8:    return a << sh;
         4'd9:    return $unsigned(a) >> sh;
         4'd10:   return a >>> sh;
         default: return 32'hffff_ffff;
      endcase
   endfunction

   function automatic logic [31:0] mk_reg(input logic [3:0] op, input int a, input int b);
      return {op, a[13:0], b[13:0]};
   endfunction

   function automatic logic [31:0] mk_shift(input logic [3:0] op, input int src, input int sh);
      return {op, src[13:0], sh[4:0], 9'h000};
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input be_word_t exp, input be_word_t act);
      if (act !== exp) begin
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
         $display("Regression failed");
         $fatal(1);
      end
   endtask

   task automatic check_count(input string name, input be_count_t exp, input be_count_t act);
      if (act !== exp) begin
         $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
         $display("Regression failed");
         $fatal(1);
      end
   endtask

   // Starts and ends on a falling edge
   task automatic send_word(input logic [31:0] w, input int gap);
      fe_queue_i   = w;
      fe_queue_v_i = 1'b1;
      @(posedge clk_i);
      while (!fe_queue_yumi_o) begin
         @(posedge clk_i);
      end
      @(negedge clk_i);
      fe_queue_v_i = 1'b0;
      repeat (gap) @(negedge clk_i);
   endtask

   task automatic wait_drain();
      while (sent_q.size() != 0) begin
         @(negedge clk_i);
      end
   endtask

   // Record accepted words and compare every transfer on the commit port
   always @(posedge clk_i) begin
      if (rst_n_i && fe_queue_v_i && fe_queue_yumi_o) begin
         sent_q.push_back(fe_queue_i);
         accept_cnt++;
      end
      if (rst_n_i && commit_v_o && commit_ready_i) begin
         if (sent_q.size() == 0) begin
            report_failure("Commit port delivered a result with no word outstanding");
         end else begin
            check_word(test_name, be_ref_exec(sent_q.pop_front()), commit_data_o);
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt >= timeout_lp) begin
         $display("Timeout: the run did not finish within %0d cycles", timeout_lp);
         $display("Regression failed");
         $fatal(1);
      end
   end

   initial begin
      logic        took;
      int          start_cnt;
      int          shamts [3];
      clk_i          = 1'b0;
      rst_n_i        = 1'b0;
      fe_queue_i     = '0;
      fe_queue_v_i   = 1'b0;
      commit_ready_i = 1'b1;
      accept_cnt     = 0;
      cycle_cnt      = 0;
      seed           = 69;
      shamts         = '{0, 1, 31};
      test_name      = "reset";

      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;
      if (fe_queue_yumi_o !== 1'b0 || commit_v_o !== 1'b0) begin
         report_failure("Handshake outputs not low after reset");
      end
      check_count("reset count", '0, commit_count_o);

      test_name = "register form";
      send_word(mk_reg(e_op_add, -5, 3), 0);
      send_word(mk_reg(e_op_sub, -8192, 8191), 0);
      send_word(mk_reg(e_op_and, -1, 'h155), 1);
      send_word(mk_reg(e_op_or, -100, 37), 0);
      send_word(mk_reg(e_op_xor, -1, -2), 0);
      wait_drain();

      test_name = "shift form";
      for (int op = 8; op <= 10; op++) begin
         for (int k = 0; k < 3; k++) begin
            send_word(mk_shift(op[3:0], (k == 2) ? -8192 : -3, shamts[k]), 0);
         end
      end
      wait_drain();

      test_name = "illegal opcode";
      for (int op = 5; op < 16; op++) begin
         if (op < 8 || op > 10) begin
            send_word(mk_reg(op[3:0], -77, 123), 0);
         end
      end
      wait_drain();

      test_name = "random";
      for (int n = 0; n < num_random_lp; n++) begin
         send_word($random(seed), $unsigned($random(seed)) % 4);
      end
      wait_drain();

      // Hold the commit port so buffers fill and credits run out
      test_name      = "backpressure";
      start_cnt      = accept_cnt;
      commit_ready_i = 1'b0;
      fe_queue_v_i   = 1'b1;
      fe_queue_i     = $random(seed);
      repeat (30) begin
         @(posedge clk_i);
         took = fe_queue_yumi_o;
         @(negedge clk_i);
         if (took) begin
            fe_queue_i = $random(seed);
         end
      end
      fe_queue_v_i = 1'b0;
      check_count("backpressure accepts", be_count_t'(stall_accepts_lp),
                  be_count_t'(accept_cnt - start_cnt));
      commit_ready_i = 1'b1;
      wait_drain();

      test_name = "final count";
      @(negedge clk_i);
      check_count(test_name, be_count_t'(accept_cnt), commit_count_o);
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/be_pkg.sv
src/be_lane_if.sv
src/be_checker.sv
src/be_calc_pipe.sv
src/be_commit.sv
src/be_top.sv
verification/be_assertions.sv
verification/be_tb.sv
